/* decode_stage.sv */
`timescale 1ns/100ps

module decode_stage (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  logic                            stall_i,
    input  logic                            flush_i,
    input  rv_isa_pkg::instr_u              instr_i,
    input  logic [rv_isa_pkg::XLEN-1:0]     pc_i,
    input  logic                            valid_i,
    input  logic                            taken_i,
    output logic                            uop_valid_o,
    output logic [rv_isa_pkg::XLEN-1:0]     uop_pc_o,
    output logic [uop_pkg::TAG_W-1:0]       uop_tag_o,
    output logic                            uop_taken_o,
    output logic [rv_isa_pkg::REG_W-1:0]    uop_rs1_o,
    output logic                            uop_rs1_en_o,
    output logic [rv_isa_pkg::REG_W-1:0]    uop_rs2_o,
    output logic                            uop_rs2_en_o,
    output logic [rv_isa_pkg::REG_W-1:0]    uop_rd_o,
    output logic                            uop_rd_alloc_o,
    output logic [rv_isa_pkg::XLEN-1:0]     uop_imm_o,
    output logic [uop_pkg::ALU_W-1:0]       uop_alu_o,
    output logic [uop_pkg::OPSEL_W-1:0]     uop_op1_o,
    output logic [uop_pkg::OPSEL_W-1:0]     uop_op2_o,
    output logic [uop_pkg::BR_W-1:0]        uop_branch_o,
    output logic [rv_isa_pkg::CSR_W-1:0]    uop_csr_addr_o,
    output logic                            uop_csr_en_o,
    output logic                            illegal_o
);
    import rv_isa_pkg::*;
    import uop_pkg::*;

    logic dec_en;
    logic load_en;
    logic known;
    logic illegal_d;
    logic is_lui, is_auipc, is_jal, is_jalr, is_beq, is_bne, is_blt, is_lw;
    logic is_sw, is_addi, is_add, is_sub, is_and, is_or, is_xor, is_csrrw;

    logic [XLEN-1:0]    imm_i;
    logic [XLEN-1:0]    imm_b;
    logic [XLEN-1:0]    imm_u;
    logic [TAG_W-1:0]   tag_r;

    logic               valid_d;
    logic               rs1_en_d;
    logic               rs2_en_d;
    logic               rd_alloc_d;
    logic               csr_en_d;
    logic [XLEN-1:0]    imm_d;
    logic [ALU_W-1:0]   alu_d;
    logic [OPSEL_W-1:0] op1_d;
    logic [OPSEL_W-1:0] op2_d;
    logic [BR_W-1:0]    br_d;

    function automatic logic hit(input logic [31:0] word, input logic [31:0] mask,
                                 input logic [31:0] pattern);
        return (word & mask) == pattern;
    endfunction

    // nothing decodes while flushing
    assign dec_en = valid_i && !flush_i;

    assign is_lui   = dec_en && hit(instr_i, MASK_LUI, MATCH_LUI);
    assign is_auipc = dec_en && hit(instr_i, MASK_AUIPC, MATCH_AUIPC);
    assign is_jal   = dec_en && hit(instr_i, MASK_JAL, MATCH_JAL);
    assign is_jalr  = dec_en && hit(instr_i, MASK_JALR, MATCH_JALR);
    assign is_beq   = dec_en && hit(instr_i, MASK_BEQ, MATCH_BEQ);
    assign is_bne   = dec_en && hit(instr_i, MASK_BNE, MATCH_BNE);
    assign is_blt   = dec_en && hit(instr_i, MASK_BLT, MATCH_BLT);
    assign is_lw    = dec_en && hit(instr_i, MASK_LW, MATCH_LW);
    assign is_sw    = dec_en && hit(instr_i, MASK_SW, MATCH_SW);
    assign is_addi  = dec_en && hit(instr_i, MASK_ADDI, MATCH_ADDI);
    assign is_add   = dec_en && hit(instr_i, MASK_ADD, MATCH_ADD);
    assign is_sub   = dec_en && hit(instr_i, MASK_SUB, MATCH_SUB);
    assign is_and   = dec_en && hit(instr_i, MASK_AND, MATCH_AND);
    assign is_or    = dec_en && hit(instr_i, MASK_OR, MATCH_OR);
    assign is_xor   = dec_en && hit(instr_i, MASK_XOR, MATCH_XOR);
    assign is_csrrw = dec_en && hit(instr_i, MASK_CSRRW, MATCH_CSRRW);

    assign known = is_lui | is_auipc | is_jal | is_jalr | is_beq | is_bne | is_blt
                 | is_lw | is_sw | is_addi | is_add | is_sub | is_and | is_or
                 | is_xor | is_csrrw;
    assign illegal_d = dec_en && !known;

    assign imm_i = {{20{instr_i.i.imm11_0[11]}}, instr_i.i.imm11_0};
    assign imm_b = {{19{instr_i.b.sign}}, instr_i.b.sign, instr_i.b.imm11,
                    instr_i.b.imm10_5, instr_i.b.imm4_1, 1'b0};
    assign imm_u = {instr_i.u.imm31_12, 12'b0};

    always_comb begin
        valid_d    = 1'b0;
        rs1_en_d   = 1'b0;
        rs2_en_d   = 1'b0;
        rd_alloc_d = 1'b0;
        csr_en_d   = 1'b0;
        imm_d      = '0;
        alu_d      = ALU_NOP;
        op1_d      = OP_RS1;
        op2_d      = OP_RS2;
        br_d       = BR_NONE;
        case (1'b1)
            is_add, is_sub, is_and, is_or, is_xor: begin
                valid_d    = 1'b1;
                rs1_en_d   = 1'b1;
                rs2_en_d   = 1'b1;
                rd_alloc_d = 1'b1;
            end
            is_addi: begin
                valid_d    = 1'b1;
                rs1_en_d   = 1'b1;
                rd_alloc_d = 1'b1;
                imm_d      = imm_i;
                op2_d      = OP_IMM;
                alu_d      = ALU_ADD;
            end
            is_lui: begin
                valid_d    = 1'b1;
                rd_alloc_d = 1'b1;
                imm_d      = imm_u;
                op1_d      = OP_ZERO;
                op2_d      = OP_IMM;
                alu_d      = ALU_ADD;
            end
            is_beq, is_bne, is_blt: begin
                // alu forms the target, the branch unit compares rs1 and rs2
                valid_d  = 1'b1;
                rs1_en_d = 1'b1;
                rs2_en_d = 1'b1;
                imm_d    = imm_b;
                op1_d    = OP_PC;
                op2_d    = OP_IMM;
                alu_d    = ALU_ADD;
            end
            is_csrrw: begin
                // still valid with rd = x0, the csr write has to happen
                valid_d    = 1'b1;
                rs1_en_d   = 1'b1;
                rd_alloc_d = (instr_i.i.rd != '0);
                csr_en_d   = 1'b1;
                op2_d      = OP_ZERO;
                alu_d      = ALU_ADD;
            end
            // auipc, jal, jalr, lw, sw leave as bubbles
            default: valid_d = 1'b0;
        endcase
        if (is_add) alu_d = ALU_ADD;
        if (is_sub) alu_d = ALU_SUB;
        if (is_and) alu_d = ALU_AND;
        if (is_or) alu_d = ALU_OR;
        if (is_xor) alu_d = ALU_XOR;
        if (is_beq) br_d = BR_EQ;
        if (is_bne) br_d = BR_NE;
        if (is_blt) br_d = BR_LT;
    end

    // flush beats stall
    assign load_en = !stall_i || flush_i;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            uop_valid_o <= 1'b0;
            illegal_o   <= 1'b0;
            uop_tag_o   <= '0;
            tag_r       <= '0;
        end else if (load_en) begin
            uop_valid_o <= valid_d;
            illegal_o   <= illegal_d;
            uop_tag_o   <= tag_r;
            if (valid_d) begin
                tag_r <= tag_r + TAG_W'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_en) begin
            uop_pc_o       <= pc_i;
            uop_taken_o    <= taken_i;
            uop_rs1_o      <= instr_i.r.rs1;
            uop_rs1_en_o   <= rs1_en_d;
            uop_rs2_o      <= instr_i.r.rs2;
            uop_rs2_en_o   <= rs2_en_d;
            uop_rd_o       <= instr_i.r.rd;
            uop_rd_alloc_o <= rd_alloc_d;
            uop_imm_o      <= imm_d;
            uop_alu_o      <= alu_d;
            uop_op1_o      <= op1_d;
            uop_op2_o      <= op2_d;
            uop_branch_o   <= br_d;
            uop_csr_addr_o <= instr_i.i.imm11_0;
            uop_csr_en_o   <= csr_en_d;
        end
    end

endmodule

/* fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        stall_i,
    input  logic                        redirect_i,
    input  logic [rv_isa_pkg::XLEN-1:0] redirect_pc_i,
    input  rv_isa_pkg::instr_u          imem_data_i,
    output logic [rv_isa_pkg::XLEN-1:0] imem_addr_o,
    output rv_isa_pkg::instr_u          instr_o,
    output logic [rv_isa_pkg::XLEN-1:0] pc_o,
    output logic                        valid_o,
    output logic                        taken_o
);
    import rv_isa_pkg::*;

    logic [XLEN-1:0] pc_r;
    logic [XLEN-1:0] pc_next;
    logic [XLEN-1:0] b_off;
    logic [XLEN-1:0] j_off;
    logic            valid_r;
    logic            is_jal;
    logic            is_bneg;

    assign b_off = {{19{imem_data_i.b.sign}}, imem_data_i.b.sign, imem_data_i.b.imm11,
                    imem_data_i.b.imm10_5, imem_data_i.b.imm4_1, 1'b0};

    // J layout is imm[20|10:1|11|19:12] in the upper twenty bits
    assign j_off = {{11{imem_data_i.u.imm31_12[19]}}, imem_data_i.u.imm31_12[19],
                    imem_data_i.u.imm31_12[7:0], imem_data_i.u.imm31_12[8],
                    imem_data_i.u.imm31_12[18:9], 1'b0};

    assign is_jal  = (imem_data_i.u.opcode == OPC_JAL);
    // backward branches predicted taken
    assign is_bneg = (imem_data_i.b.opcode == OPC_BRANCH) && imem_data_i.b.sign;

    always_comb begin
        if (redirect_i) begin
            pc_next = redirect_pc_i;
        end else if (stall_i || !valid_r) begin
            // first word after reset is held until valid rises
            pc_next = pc_r;
        end else if (is_jal) begin
            pc_next = pc_r + j_off;
        end else if (is_bneg) begin
            pc_next = pc_r + b_off;
        end else begin
            pc_next = pc_r + 32'd4;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            pc_r    <= RESET_PC;
            valid_r <= 1'b0;
        end else begin
            pc_r    <= pc_next;
            valid_r <= 1'b1;
        end
    end

    assign imem_addr_o = pc_r;
    assign pc_o        = pc_r;
    assign instr_o     = imem_data_i;
    assign valid_o     = valid_r;
    assign taken_o     = valid_r && (is_jal || is_bneg);

endmodule

/* rv_frontend.f */
rv_isa_pkg.sv
uop_pkg.sv
fetch_stage.sv
decode_stage.sv
rv_frontend.sv
rv_frontend_asserts.sv
rv_frontend_tb.sv

/* rv_frontend.sv */
`timescale 1ns/100ps

module rv_frontend (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  logic                            stall_i,
    input  logic                            redirect_i,
    input  logic [rv_isa_pkg::XLEN-1:0]     redirect_pc_i,
    output logic [rv_isa_pkg::XLEN-1:0]     imem_addr_o,
    input  rv_isa_pkg::instr_u              imem_data_i,
    output logic                            uop_valid_o,
    output logic [rv_isa_pkg::XLEN-1:0]     uop_pc_o,
    output logic [uop_pkg::TAG_W-1:0]       uop_tag_o,
    output logic                            uop_taken_o,
    output logic [rv_isa_pkg::REG_W-1:0]    uop_rs1_o,
    output logic                            uop_rs1_en_o,
    output logic [rv_isa_pkg::REG_W-1:0]    uop_rs2_o,
    output logic                            uop_rs2_en_o,
    output logic [rv_isa_pkg::REG_W-1:0]    uop_rd_o,
    output logic                            uop_rd_alloc_o,
    output logic [rv_isa_pkg::XLEN-1:0]     uop_imm_o,
    output logic [uop_pkg::ALU_W-1:0]       uop_alu_o,
    output logic [uop_pkg::OPSEL_W-1:0]     uop_op1_o,
    output logic [uop_pkg::OPSEL_W-1:0]     uop_op2_o,
    output logic [uop_pkg::BR_W-1:0]        uop_branch_o,
    output logic [rv_isa_pkg::CSR_W-1:0]    uop_csr_addr_o,
    output logic                            uop_csr_en_o,
    output logic                            illegal_o
);
    import rv_isa_pkg::*;

    instr_u          fetch_instr;
    logic [XLEN-1:0] fetch_pc;
    logic            fetch_valid;
    logic            fetch_taken;

    fetch_stage u_fetch (
        .*,
        .instr_o (fetch_instr),
        .pc_o    (fetch_pc),
        .valid_o (fetch_valid),
        .taken_o (fetch_taken)
    );

    // redirect also squashes the word sitting in decode
    decode_stage u_decode (
        .*,
        .flush_i (redirect_i),
        .instr_i (fetch_instr),
        .pc_i    (fetch_pc),
        .valid_i (fetch_valid),
        .taken_i (fetch_taken)
    );

endmodule

/* rv_frontend_asserts.sv */
`timescale 1ns/100ps

module rv_frontend_asserts (
    input logic                        clk_i,
    input logic                        rstn_i,
    input logic                        stall_i,
    input logic                        redirect_i,
    input logic [rv_isa_pkg::XLEN-1:0] imem_addr_o,
    input logic                        uop_valid_o,
    input logic [rv_isa_pkg::XLEN-1:0] uop_pc_o,
    input logic [uop_pkg::TAG_W-1:0]   uop_tag_o,
    input logic                        illegal_o
);
    import rv_isa_pkg::*;

    int fail_count = 0;

    // first edge out of reset sees the reset values
    a_reset_quiet: assert property (@(posedge clk_i)
        rstn_i && !$past(rstn_i) |-> !uop_valid_o && !illegal_o && uop_tag_o == '0
            && imem_addr_o == RESET_PC)
    else begin
        fail_count++;
        $error("outputs not in reset state on the first edge after reset");
    end

    a_stall_hold: assert property (@(posedge clk_i)
        rstn_i && stall_i && !redirect_i |=> $stable(uop_valid_o) && $stable(uop_tag_o)
            && $stable(uop_pc_o) && $stable(imem_addr_o))
    else begin
        fail_count++;
        $error("micro-op, tag or fetch address changed during a stall");
    end

    a_redirect_bubble: assert property (@(posedge clk_i)
        rstn_i && redirect_i |=> !uop_valid_o)
    else begin
        fail_count++;
        $error("valid micro-op in the cycle after a redirect");
    end

    a_valid_xor_illegal: assert property (@(posedge clk_i)
        rstn_i |-> !(uop_valid_o && illegal_o))
    else begin
        fail_count++;
        $error("illegal flag raised on a valid micro-op");
    end

endmodule

bind rv_frontend rv_frontend_asserts u_asserts (.*);

/* rv_frontend_tb.sv */
`timescale 1ns/100ps

module rv_frontend_tb;
    import rv_isa_pkg::*;
    import uop_pkg::*;

    localparam int TIMEOUT_CYCLES = 400;

    logic               clk_i;
    logic               rstn_i;
    logic               stall_i;
    logic               redirect_i;
    logic [XLEN-1:0]    redirect_pc_i;
    logic [XLEN-1:0]    imem_addr_o;
    instr_u             imem_data_i;
    logic               uop_valid_o;
    logic [XLEN-1:0]    uop_pc_o;
    logic [TAG_W-1:0]   uop_tag_o;
    logic               uop_taken_o;
    logic [REG_W-1:0]   uop_rs1_o;
    logic               uop_rs1_en_o;
    logic [REG_W-1:0]   uop_rs2_o;
    logic               uop_rs2_en_o;
    logic [REG_W-1:0]   uop_rd_o;
    logic               uop_rd_alloc_o;
    logic [XLEN-1:0]    uop_imm_o;
    logic [ALU_W-1:0]   uop_alu_o;
    logic [OPSEL_W-1:0] uop_op1_o;
    logic [OPSEL_W-1:0] uop_op2_o;
    logic [BR_W-1:0]    uop_branch_o;
    logic [CSR_W-1:0]   uop_csr_addr_o;
    logic               uop_csr_en_o;
    logic               illegal_o;

    logic [31:0]        imem [64];
    logic [31:0]        lfsr_q = 32'hb59ccfdf;
    logic [TAG_W-1:0]   exp_tag = '0;
    logic               load_seen = 1'b0;
    int                 errors = 0;
    int                 cycle_cnt = 0;

    rv_frontend u_dut (.*);

    // instruction memory answers in the same cycle
    assign imem_data_i = imem[imem_addr_o[7:2]];

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
            val = {val[30:0], lfsr_q[0]};
        end
        return val;
    endfunction

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        instr_u w;
        w.r.funct7 = f7;
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = f3;
        w.r.rd     = rd;
        w.r.opcode = 7'h33;
        return w;
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        instr_u w;
        w.i.imm11_0 = imm;
        w.i.rs1     = rs1;
        w.i.funct3  = f3;
        w.i.rd      = rd;
        w.i.opcode  = opc;
        return w;
    endfunction

    function automatic logic [31:0] b_word(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        instr_u w;
        w.b.sign    = off[12];
        w.b.imm11   = off[11];
        w.b.imm10_5 = off[10:5];
        w.b.imm4_1  = off[4:1];
        w.b.rs2     = rs2;
        w.b.rs1     = rs1;
        w.b.funct3  = f3;
        w.b.opcode  = 7'h63;
        return w;
    endfunction

    function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        instr_u w;
        w.u.imm31_12 = imm;
        w.u.rd       = rd;
        w.u.opcode   = opc;
        return w;
    endfunction

    // J offset bits sit as imm[20|10:1|11|19:12]
    function automatic logic [31:0] j_word(input logic [20:0] off, input logic [4:0] rd);
        return u_word({off[20], off[10:1], off[11], off[19:12]}, rd, 7'h6f);
    endfunction

    // tags step by one on every newly loaded valid micro-op
    always @(negedge clk_i) begin
        if (rstn_i && load_seen && uop_valid_o) begin
            check_val("tag sequence", 32'(exp_tag), 32'(uop_tag_o));
            exp_tag = exp_tag + 1'b1;
        end
        load_seen = rstn_i && (!stall_i || redirect_i);
    end

    task automatic redirect_to(input logic [31:0] target, input logic with_stall);
        @(posedge clk_i);
        redirect_i    <= 1'b1;
        redirect_pc_i <= target;
        stall_i       <= with_stall;
        @(posedge clk_i);
        redirect_i <= 1'b0;
        stall_i    <= 1'b0;
        @(negedge clk_i);
        check_val("redirect imem_addr", target, imem_addr_o);
        check_val("redirect bubble valid", 32'd0, uop_valid_o);
    endtask

    task automatic reset_values();
        @(negedge clk_i);
        check_val("reset imem_addr", RESET_PC, imem_addr_o);
        check_val("reset uop_valid", 32'd0, uop_valid_o);
        check_val("reset illegal", 32'd0, illegal_o);
        check_val("reset tag", 32'd0, uop_tag_o);
        check_val("reset fetch_valid", 32'd0, u_dut.fetch_valid);
        @(negedge clk_i);
        check_val("reset fetch_valid rise", 32'd1, u_dut.fetch_valid);
        check_val("reset no uop yet", 32'd0, uop_valid_o);
        @(negedge clk_i);
        check_val("reset first uop valid", 32'd1, uop_valid_o);
        check_val("reset first uop pc", RESET_PC, uop_pc_o);
        check_val("reset first uop tag", 32'd0, uop_tag_o);
    endtask

    task automatic alu_decode();
        int               kind_q [14];
        logic [4:0]       rs1_q [14];
        logic [4:0]       rs2_q [14];
        logic [4:0]       rd_q [14];
        logic [19:0]      imm_q [14];
        logic [ALU_W-1:0] r_alu;
        string            nm;
        for (int n = 0; n < 14; n++) begin
            kind_q[n] = n % 7;
            rs1_q[n]  = 5'(rand_bits(5));
            rs2_q[n]  = 5'(rand_bits(5));
            rd_q[n]   = 5'(rand_bits(5));
            imm_q[n]  = 20'(rand_bits(20));
            case (kind_q[n])
                0: imem[16 + n] = r_word(7'h00, rs2_q[n], rs1_q[n], 3'b000, rd_q[n]);
                1: imem[16 + n] = r_word(7'h20, rs2_q[n], rs1_q[n], 3'b000, rd_q[n]);
                2: imem[16 + n] = r_word(7'h00, rs2_q[n], rs1_q[n], 3'b111, rd_q[n]);
                3: imem[16 + n] = r_word(7'h00, rs2_q[n], rs1_q[n], 3'b110, rd_q[n]);
                4: imem[16 + n] = r_word(7'h00, rs2_q[n], rs1_q[n], 3'b100, rd_q[n]);
                5: imem[16 + n] = i_word(imm_q[n][11:0], rs1_q[n], 3'b000, rd_q[n], 7'h13);
                default: imem[16 + n] = u_word(imm_q[n], rd_q[n], 7'h37);
            endcase
        end
        redirect_to(32'h40, 1'b0);
        for (int n = 0; n < 14; n++) begin
            @(negedge clk_i);
            nm = $sformatf("alu_decode[%0d]", n);
            check_val({nm, " valid"}, 32'd1, uop_valid_o);
            check_val({nm, " pc"}, 32'h40 + 4 * n, uop_pc_o);
            check_val({nm, " rd"}, rd_q[n], uop_rd_o);
            check_val({nm, " rd_alloc"}, 32'd1, uop_rd_alloc_o);
            check_val({nm, " branch"}, BR_NONE, uop_branch_o);
            if (kind_q[n] <= 4) begin
                case (kind_q[n])
                    0: r_alu = ALU_ADD;
                    1: r_alu = ALU_SUB;
                    2: r_alu = ALU_AND;
                    3: r_alu = ALU_OR;
                    default: r_alu = ALU_XOR;
                endcase
                check_val({nm, " rs1"}, rs1_q[n], uop_rs1_o);
                check_val({nm, " rs2"}, rs2_q[n], uop_rs2_o);
                check_val({nm, " rs1_en"}, 32'd1, uop_rs1_en_o);
                check_val({nm, " rs2_en"}, 32'd1, uop_rs2_en_o);
                check_val({nm, " op1"}, OP_RS1, uop_op1_o);
                check_val({nm, " op2"}, OP_RS2, uop_op2_o);
                check_val({nm, " alu"}, r_alu, uop_alu_o);
            end else if (kind_q[n] == 5) begin
                check_val({nm, " rs1"}, rs1_q[n], uop_rs1_o);
                check_val({nm, " rs1_en"}, 32'd1, uop_rs1_en_o);
                check_val({nm, " rs2_en"}, 32'd0, uop_rs2_en_o);
                check_val({nm, " op1"}, OP_RS1, uop_op1_o);
                check_val({nm, " op2"}, OP_IMM, uop_op2_o);
                check_val({nm, " alu"}, ALU_ADD, uop_alu_o);
                check_val({nm, " imm"}, {{20{imm_q[n][11]}}, imm_q[n][11:0]}, uop_imm_o);
            end else begin
                check_val({nm, " rs1_en"}, 32'd0, uop_rs1_en_o);
                check_val({nm, " rs2_en"}, 32'd0, uop_rs2_en_o);
                check_val({nm, " op1"}, OP_ZERO, uop_op1_o);
                check_val({nm, " op2"}, OP_IMM, uop_op2_o);
                check_val({nm, " alu"}, ALU_ADD, uop_alu_o);
                check_val({nm, " imm"}, {imm_q[n], 12'h000}, uop_imm_o);
            end
        end
    endtask

    task automatic branch_predict();
        logic [4:0] ra;
        logic [4:0] rb;
        ra = 5'(rand_bits(5));
        rb = 5'(rand_bits(5));
        // 0x80 beq +12, 0x84 jal +16, 0x94 bne +8, 0x98 blt -16 back to 0x88
        imem[32] = b_word(13'd12, rb, ra, 3'b000);
        imem[33] = j_word(21'd16, 5'd1);
        imem[34] = i_word(12'h7ff, ra, 3'b000, rb, 7'h13);
        imem[37] = b_word(13'd8, ra, rb, 3'b001);
        imem[38] = b_word(13'h1ff0, rb, ra, 3'b100);
        redirect_to(32'h80, 1'b0);
        @(negedge clk_i);
        check_val("beq valid", 32'd1, uop_valid_o);
        check_val("beq pc", 32'h80, uop_pc_o);
        check_val("beq branch", BR_EQ, uop_branch_o);
        check_val("beq imm", 32'd12, uop_imm_o);
        check_val("beq taken", 32'd0, uop_taken_o);
        check_val("beq rs1", ra, uop_rs1_o);
        check_val("beq rs2", rb, uop_rs2_o);
        @(negedge clk_i);
        check_val("jal valid", 32'd0, uop_valid_o);
        check_val("jal illegal", 32'd0, illegal_o);
        check_val("jal pc", 32'h84, uop_pc_o);
        check_val("jal taken", 32'd1, uop_taken_o);
        @(negedge clk_i);
        check_val("bne pc", 32'h94, uop_pc_o);
        check_val("bne branch", BR_NE, uop_branch_o);
        check_val("bne imm", 32'd8, uop_imm_o);
        check_val("bne taken", 32'd0, uop_taken_o);
        @(negedge clk_i);
        check_val("blt pc", 32'h98, uop_pc_o);
        check_val("blt branch", BR_LT, uop_branch_o);
        check_val("blt imm", 32'hffff_fff0, uop_imm_o);
        check_val("blt taken", 32'd1, uop_taken_o);
        @(negedge clk_i);
        check_val("blt target pc", 32'h88, uop_pc_o);
        check_val("blt target valid", 32'd1, uop_valid_o);
    endtask

    task automatic csr_and_illegal();
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [11:0] csr_a;
        logic [11:0] csr_b;
        rd    = {4'(rand_bits(4)), 1'b1};
        rs    = 5'(rand_bits(5));
        csr_a = 12'(rand_bits(12));
        csr_b = 12'(rand_bits(12));
        imem[48] = i_word(csr_a, rs, 3'b001, rd, 7'h73);
        imem[49] = i_word(csr_b, rs, 3'b001, 5'd0, 7'h73);
        imem[50] = i_word(12'(rand_bits(12)), rs, 3'b010, rd, 7'h03);
        imem[51] = 32'h0000_0000;
        imem[52] = i_word(12'h001, rs, 3'b000, rd, 7'h13);
        redirect_to(32'hc0, 1'b0);
        @(negedge clk_i);
        check_val("csrrw valid", 32'd1, uop_valid_o);
        check_val("csrrw csr_en", 32'd1, uop_csr_en_o);
        check_val("csrrw csr_addr", csr_a, uop_csr_addr_o);
        check_val("csrrw rd", rd, uop_rd_o);
        check_val("csrrw rd_alloc", 32'd1, uop_rd_alloc_o);
        check_val("csrrw rs1", rs, uop_rs1_o);
        @(negedge clk_i);
        check_val("csrrw x0 valid", 32'd1, uop_valid_o);
        check_val("csrrw x0 csr_en", 32'd1, uop_csr_en_o);
        check_val("csrrw x0 csr_addr", csr_b, uop_csr_addr_o);
        check_val("csrrw x0 rd_alloc", 32'd0, uop_rd_alloc_o);
        @(negedge clk_i);
        check_val("lw valid", 32'd0, uop_valid_o);
        check_val("lw illegal", 32'd0, illegal_o);
        check_val("lw pc", 32'hc8, uop_pc_o);
        @(negedge clk_i);
        check_val("zero word illegal", 32'd1, illegal_o);
        check_val("zero word valid", 32'd0, uop_valid_o);
        @(negedge clk_i);
        check_val("after illegal valid", 32'd1, uop_valid_o);
        check_val("after illegal pc", 32'hd0, uop_pc_o);
    endtask

    task automatic stall_hold();
        logic [XLEN-1:0]  pc_snap;
        logic [XLEN-1:0]  addr_snap;
        logic [XLEN-1:0]  imm_snap;
        logic [TAG_W-1:0] tag_snap;
        logic             valid_snap;
        redirect_to(32'h20, 1'b0);
        @(negedge clk_i);
        check_val("stall_hold first pc", 32'h20, uop_pc_o);
        @(posedge clk_i);
        stall_i <= 1'b1;
        @(negedge clk_i);
        check_val("stall_hold pc before stall", 32'h24, uop_pc_o);
        pc_snap    = uop_pc_o;
        addr_snap  = imem_addr_o;
        imm_snap   = uop_imm_o;
        tag_snap   = uop_tag_o;
        valid_snap = uop_valid_o;
        for (int k = 0; k < 3; k++) begin
            if (k == 2) begin
                @(posedge clk_i);
                stall_i <= 1'b0;
            end
            @(negedge clk_i);
            check_val("stall_hold pc", pc_snap, uop_pc_o);
            check_val("stall_hold imem_addr", addr_snap, imem_addr_o);
            check_val("stall_hold imm", imm_snap, uop_imm_o);
            check_val("stall_hold tag", 32'(tag_snap), 32'(uop_tag_o));
            check_val("stall_hold valid", valid_snap, uop_valid_o);
        end
        // sequence resumes with the word that waited in fetch
        @(negedge clk_i);
        check_val("stall_hold resume pc", 32'h28, uop_pc_o);
        check_val("stall_hold resume valid", 32'd1, uop_valid_o);
        @(negedge clk_i);
        check_val("stall_hold next pc", 32'h2c, uop_pc_o);
    endtask

    task automatic redirect_flush();
        redirect_to(32'h44, 1'b0);
        @(negedge clk_i);
        check_val("redirect target valid", 32'd1, uop_valid_o);
        check_val("redirect target pc", 32'h44, uop_pc_o);
        // stall raised on the same edge as the redirect
        redirect_to(32'h24, 1'b1);
        @(negedge clk_i);
        check_val("redirect over stall valid", 32'd1, uop_valid_o);
        check_val("redirect over stall pc", 32'h24, uop_pc_o);
    endtask

    initial begin
        rstn_i        = 1'b0;
        stall_i       = 1'b0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        // addi x[i], x[i], i in every word
        for (int i = 0; i < 64; i++) begin
            imem[i] = i_word(12'(i), 5'(i), 3'b000, 5'(i), 7'h13);
        end
        repeat (16) @(posedge clk_i);
        rstn_i <= 1'b1;
        reset_values();
        alu_decode();
        branch_predict();
        csr_and_illegal();
        stall_hold();
        redirect_flush();
        repeat (2) @(negedge clk_i);
        $display("errors: %0d check, %0d assertion", errors, u_dut.u_asserts.fail_count);
        if (errors == 0 && u_dut.u_asserts.fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* rv_isa_pkg.sv */
package rv_isa_pkg;

    localparam int XLEN  = 32;
    localparam int REG_W = 5;
    localparam int CSR_W = 12;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // major opcodes fetch looks at for prediction
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
    localparam logic [6:0] OPC_JAL    = 7'b110_1111;

    localparam logic [31:0] MASK_LUI   = 32'h0000_007f, MATCH_LUI   = 32'h0000_0037;
    localparam logic [31:0] MASK_AUIPC = 32'h0000_007f, MATCH_AUIPC = 32'h0000_0017;
    localparam logic [31:0] MASK_JAL   = 32'h0000_007f, MATCH_JAL   = 32'h0000_006f;
    localparam logic [31:0] MASK_JALR  = 32'h0000_707f, MATCH_JALR  = 32'h0000_0067;
    localparam logic [31:0] MASK_BEQ   = 32'h0000_707f, MATCH_BEQ   = 32'h0000_0063;
    localparam logic [31:0] MASK_BNE   = 32'h0000_707f, MATCH_BNE   = 32'h0000_1063;
    localparam logic [31:0] MASK_BLT   = 32'h0000_707f, MATCH_BLT   = 32'h0000_4063;
    localparam logic [31:0] MASK_LW    = 32'h0000_707f, MATCH_LW    = 32'h0000_2003;
    localparam logic [31:0] MASK_SW    = 32'h0000_707f, MATCH_SW    = 32'h0000_2023;
    localparam logic [31:0] MASK_ADDI  = 32'h0000_707f, MATCH_ADDI  = 32'h0000_0013;
    localparam logic [31:0] MASK_ADD   = 32'hfe00_707f, MATCH_ADD   = 32'h0000_0033;
    localparam logic [31:0] MASK_SUB   = 32'hfe00_707f, MATCH_SUB   = 32'h4000_0033;
    localparam logic [31:0] MASK_AND   = 32'hfe00_707f, MATCH_AND   = 32'h0000_7033;
    localparam logic [31:0] MASK_OR    = 32'hfe00_707f, MATCH_OR    = 32'h0000_6033;
    localparam logic [31:0] MASK_XOR   = 32'hfe00_707f, MATCH_XOR   = 32'h0000_4033;
    localparam logic [31:0] MASK_CSRRW = 32'h0000_707f, MATCH_CSRRW = 32'h0000_1073;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       sign;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    // also carries the J immediate, scrambled
    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
    } instr_u;

endpackage

/* uop_pkg.sv */
package uop_pkg;

    localparam int TAG_W = 4;

    localparam int ALU_W = 3;
    localparam logic [ALU_W-1:0] ALU_NOP   = 3'd0;
    localparam logic [ALU_W-1:0] ALU_ADD   = 3'd1;
    localparam logic [ALU_W-1:0] ALU_SUB   = 3'd2;
    localparam logic [ALU_W-1:0] ALU_AND   = 3'd3;
    localparam logic [ALU_W-1:0] ALU_OR    = 3'd4;
    localparam logic [ALU_W-1:0] ALU_XOR   = 3'd5;
    localparam logic [ALU_W-1:0] ALU_PASS2 = 3'd6;

    // operand selects are decoded per slot, so codes repeat between op1 and op2
    localparam int OPSEL_W = 2;
    // op1 slot
    localparam logic [OPSEL_W-1:0] OP_RS1  = 2'd0;
    localparam logic [OPSEL_W-1:0] OP_PC   = 2'd1;
    // op2 slot
    localparam logic [OPSEL_W-1:0] OP_RS2  = 2'd0;
    localparam logic [OPSEL_W-1:0] OP_IMM  = 2'd1;
    // valid in either slot
    localparam logic [OPSEL_W-1:0] OP_ZERO = 2'd2;

    localparam int BR_W = 2;
    localparam logic [BR_W-1:0] BR_NONE = 2'd0;
    localparam logic [BR_W-1:0] BR_EQ   = 2'd1;
    localparam logic [BR_W-1:0] BR_NE   = 2'd2;
    localparam logic [BR_W-1:0] BR_LT   = 2'd3;

endpackage
